// File: source/rden_cal_defines.svh
`ifndef RDEN_CAL_DEFINES_SVH
`define RDEN_CAL_DEFINES_SVH

// width of one read-enable delay value
// five bits address every tap of a 32-deep shift delay
`define RDEN_DLY_W 5

// last delay the search is allowed to try before it gives up
`define RDEN_DLY_MAX 31

// first delay tried for every DQS group
// smaller values can never line up with the deserializer output
`define RDEN_BASE_DELAY 2

// offset between the shift value that matched the training pattern and
// the delay reported for normal reads
// the pattern decoder adds one register stage that normal reads do not see
`define RDEN_DLY_DELTA 1

// idle cycles before each probe so that the probe delay line is empty
// this has to exceed the delay line depth
`define RDEN_PIPE_CLR_LEN 40

`endif

// File: source/rden_cal_pkg.sv
`include "rden_cal_defines.svh"

package rden_cal_pkg;

  // one read-enable delay, used for the probe and for every group
  typedef logic [`RDEN_DLY_W-1:0] rden_dly_t;

  // states of the per-group read-enable search
  typedef enum logic [2:0] {
    CAL3_IDLE,
    CAL3_INIT,
    CAL3_PIPE_CLR_WAIT,
    CAL3_DETECT,
    CAL3_DONE
  } cal3_state_t;

  // one group's deserializer output for one clkdiv cycle
  // index 0 of each field is DQ bit 0 of the group, index 1 is DQ bit 1
  // the q2 half carries the earlier two beats when the data is aligned
  typedef struct packed {
    logic [1:0] rise_q2;
    logic [1:0] fall_q2;
    logic [1:0] rise_q1;
    logic [1:0] fall_q1;
  } rdd_sample_t;

  // width of a group index, kept at one bit for a single group
  function automatic int grp_w(input int num_grp);
    return (num_grp > 1) ? $clog2(num_grp) : 1;
  endfunction

endpackage

// File: source/rdd_pattern_decode.sv
`timescale 1ns/1ps

module rdd_pattern_decode
  import rden_cal_pkg::*;
#(
  parameter int DQS_WIDTH = 4
) (
  input  logic                        clkdiv,
  input  rdd_sample_t [DQS_WIDTH-1:0] rdd_i,
  output logic        [DQS_WIDTH-1:0] match_aligned_o,
  output logic        [DQS_WIDTH-1:0] match_stgd_o
);

  // first seven beats of the training pattern on DQ bit 0, first beat on the left
  // the eighth beat is skipped since the read postamble can disturb it
  localparam logic [6:0] PAT_B0 = 7'b1001010;
  // DQ bit 1 carries the complement so a stuck bus cannot fake a match
  localparam logic [6:0] PAT_B1 = 7'b0110101;

  // two older copies of every group's word
  // rdd_r is one cycle old and rdd_r1 is two cycles old
  rdd_sample_t [DQS_WIDTH-1:0] rdd_r;
  rdd_sample_t [DQS_WIDTH-1:0] rdd_r1;

  // combinational hit per group before the output register
  logic [DQS_WIDTH-1:0] hit_aligned;
  logic [DQS_WIDTH-1:0] hit_stgd;

  always_ff @(posedge clkdiv) begin
    rdd_r  <= rdd_i;
    rdd_r1 <= rdd_r;
  end

  for (genvar g = 0; g < DQS_WIDTH; g++) begin : gen_grp
    logic [6:0] al_b0;
    logic [6:0] al_b1;
    logic [6:0] st_b0;
    logic [6:0] st_b1;

    // aligned burst, beats 0-3 sit in the older word as q2 rise, q2 fall,
    // q1 rise and q1 fall, and beats 4-6 follow in the current word
    assign al_b0 = {rdd_r[g].rise_q2[0], rdd_r[g].fall_q2[0],
                    rdd_r[g].rise_q1[0], rdd_r[g].fall_q1[0],
                    rdd_i[g].rise_q2[0], rdd_i[g].fall_q2[0],
                    rdd_i[g].rise_q1[0]};
    assign al_b1 = {rdd_r[g].rise_q2[1], rdd_r[g].fall_q2[1],
                    rdd_r[g].rise_q1[1], rdd_r[g].fall_q1[1],
                    rdd_i[g].rise_q2[1], rdd_i[g].fall_q2[1],
                    rdd_i[g].rise_q1[1]};

    // staggered burst is half a word pair late
    // beats 0-1 are in the q1 half of the oldest word, beats 2-5 fill the
    // middle word and beat 6 is the q2 rise of the current word
    assign st_b0 = {rdd_r1[g].rise_q1[0], rdd_r1[g].fall_q1[0],
                    rdd_r[g].rise_q2[0],  rdd_r[g].fall_q2[0],
                    rdd_r[g].rise_q1[0],  rdd_r[g].fall_q1[0],
                    rdd_i[g].rise_q2[0]};
    assign st_b1 = {rdd_r1[g].rise_q1[1], rdd_r1[g].fall_q1[1],
                    rdd_r[g].rise_q2[1],  rdd_r[g].fall_q2[1],
                    rdd_r[g].rise_q1[1],  rdd_r[g].fall_q1[1],
                    rdd_i[g].rise_q2[1]};

    assign hit_aligned[g] = (al_b0 == PAT_B0) && (al_b1 == PAT_B1);
    assign hit_stgd[g]    = (st_b0 == PAT_B0) && (st_b1 == PAT_B1);
  end

  // the flags are registered, so a flag seen in cycle T covers the words of
  // cycles T-2 and T-1 (aligned) or T-3 to T-1 (staggered)
  always_ff @(posedge clkdiv) begin
    match_aligned_o <= hit_aligned;
    match_stgd_o    <= hit_stgd;
  end

endmodule

// File: source/rden_delay_line.sv
`timescale 1ns/1ps

module rden_delay_line
  import rden_cal_pkg::*;
#(
  parameter int NUM_LANES = 1
) (
  input  logic                      clkdiv,
  input  logic                      rstdiv,
  input  logic      [NUM_LANES-1:0] rden_i,
  input  rden_dly_t [NUM_LANES-1:0] dly_i,
  output logic      [NUM_LANES-1:0] rden_o
);

  // one tap per delay value
  localparam int DEPTH = 2 ** $bits(rden_dly_t);

  // tap 0 is the live input, the other taps come from the history register
  // so the history only needs DEPTH-1 stored bits per lane
  logic [NUM_LANES-1:0][DEPTH-2:0] hist;
  logic [NUM_LANES-1:0][DEPTH-1:0] taps;
  logic [NUM_LANES-1:0]            tap_sel;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      taps[l]    = {hist[l], rden_i[l]};
      // each lane picks the tap its own delay points at
      tap_sel[l] = taps[l][dly_i[l]];
    end
  end

  // a pulse entered in cycle P with delay d leaves the output register in
  // cycle P+d+1
  always_ff @(posedge clkdiv) begin
    if (rstdiv) begin
      hist   <= '0;
      rden_o <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        hist[l] <= taps[l][DEPTH-2:0];
      end
      rden_o <= tap_sel;
    end
  end

endmodule

// File: source/rden_search_exec.sv
`timescale 1ns/1ps

`include "rden_cal_defines.svh"

module rden_search_exec
  import rden_cal_pkg::*;
#(
  parameter  int DQS_WIDTH = 4,
  localparam int GRP_W     = grp_w(DQS_WIDTH)
) (
  input  logic                      clkdiv,
  input  logic                      rstdiv,
  input  logic                      calib_start_i,
  input  logic      [DQS_WIDTH-1:0] match_aligned_i,
  input  logic      [DQS_WIDTH-1:0] match_stgd_i,
  input  logic                      probe_valid_i,
  output logic                      probe_rden_o,
  output rden_dly_t                 probe_dly_o,
  output rden_dly_t [DQS_WIDTH-1:0] grp_dly_o,
  output logic                      rec_o,
  output logic      [GRP_W-1:0]     rec_grp_o,
  output rden_dly_t                 rec_dly_o,
  output logic                      search_err_o,
  output logic                      done_o
);

  localparam int PCNT_W = $clog2(`RDEN_PIPE_CLR_LEN);

  cal3_state_t       cal3_state;
  logic [PCNT_W-1:0] pipe_cnt;
  logic [GRP_W-1:0]  grp_cnt;
  logic              start_r;
  logic              start_edge;
  logic              valid_stgd;
  logic              al_hit;
  logic              match_found;
  rden_dly_t         found_dly;

  // calibration starts on a rising edge of the start level only
  assign start_edge = calib_start_i & ~start_r;

  // the staggered pattern completes one cycle after the aligned one, so the
  // aligned result is held in al_hit and both are judged on valid_stgd
  assign match_found = valid_stgd & (al_hit | match_stgd_i[grp_cnt]);

  // reported delay drops the decoder's extra register stage
  assign found_dly = probe_dly_o - rden_dly_t'(`RDEN_DLY_DELTA);

  always_ff @(posedge clkdiv) begin
    if (rstdiv) begin
      start_r    <= 1'b0;
      valid_stgd <= 1'b0;
    end else begin
      start_r    <= calib_start_i;
      // the staggered valid is the probe valid one clkdiv cycle later
      valid_stgd <= probe_valid_i;
    end
  end

  // record payload is qualified by rec_o
  always_ff @(posedge clkdiv) begin
    if ((cal3_state == CAL3_DETECT) && match_found) begin
      rec_grp_o <= grp_cnt;
      rec_dly_o <= found_dly;
    end
  end

  always_ff @(posedge clkdiv) begin
    if (rstdiv) begin
      cal3_state   <= CAL3_IDLE;
      pipe_cnt     <= '0;
      grp_cnt      <= '0;
      al_hit       <= 1'b0;
      probe_rden_o <= 1'b0;
      probe_dly_o  <= '0;
      grp_dly_o    <= '0;
      rec_o        <= 1'b0;
      search_err_o <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      // probe and record strobes are single-cycle pulses
      probe_rden_o <= 1'b0;
      rec_o        <= 1'b0;
      case (cal3_state)
        CAL3_IDLE: begin
          grp_cnt <= '0;
          if (start_edge) begin
            // a new run forgets both the old result and the old error
            done_o       <= 1'b0;
            search_err_o <= 1'b0;
            cal3_state   <= CAL3_INIT;
          end
        end
        CAL3_INIT: begin
          probe_dly_o <= rden_dly_t'(`RDEN_BASE_DELAY);
          pipe_cnt    <= PCNT_W'(`RDEN_PIPE_CLR_LEN - 1);
          cal3_state  <= CAL3_PIPE_CLR_WAIT;
        end
        CAL3_PIPE_CLR_WAIT: begin
          // wait until no pulse of an earlier delay is left in the probe line
          al_hit <= 1'b0;
          if (pipe_cnt == '0) begin
            probe_rden_o <= 1'b1;
            cal3_state   <= CAL3_DETECT;
          end else begin
            pipe_cnt <= pipe_cnt - 1'b1;
          end
        end
        CAL3_DETECT: begin
          if (probe_valid_i) begin
            al_hit <= match_aligned_i[grp_cnt];
          end
          if (valid_stgd) begin
            if (match_found) begin
              grp_dly_o[grp_cnt] <= found_dly;
              rec_o              <= 1'b1;
              cal3_state         <= CAL3_DONE;
            end else if (probe_dly_o == rden_dly_t'(`RDEN_DLY_MAX)) begin
              // whole delay range tried without a match
              search_err_o <= 1'b1;
              cal3_state   <= CAL3_IDLE;
            end else begin
              probe_dly_o <= probe_dly_o + 1'b1;
              pipe_cnt    <= PCNT_W'(`RDEN_PIPE_CLR_LEN - 1);
              cal3_state  <= CAL3_PIPE_CLR_WAIT;
            end
          end
        end
        CAL3_DONE: begin
          if (grp_cnt == GRP_W'(DQS_WIDTH - 1)) begin
            done_o     <= 1'b1;
            cal3_state <= CAL3_IDLE;
          end else begin
            grp_cnt    <= grp_cnt + 1'b1;
            cal3_state <= CAL3_INIT;
          end
        end
        default: cal3_state <= CAL3_IDLE;
      endcase
    end
  end

endmodule

// File: source/rden_skew_result.sv
`timescale 1ns/1ps

module rden_skew_result
  import rden_cal_pkg::*;
#(
  parameter  int DQS_WIDTH = 4,
  localparam int GRP_W     = grp_w(DQS_WIDTH)
) (
  input  logic                 clkdiv,
  input  logic                 rstdiv,
  input  logic                 rec_i,
  input  logic     [GRP_W-1:0] rec_grp_i,
  input  rden_dly_t            rec_dly_i,
  input  logic                 done_i,
  input  logic                 search_err_i,
  output logic [DQS_WIDTH-1:0] rden_sel_o,
  output logic                 calib_err_o
);

  // group 0 delay is the reference for all other groups
  rden_dly_t            ref_dly;
  // a set bit marks a group whose delay differs from group 0
  logic [DQS_WIDTH-1:0] rden_mux;
  // inc means some group is earlier than group 0 and dec means some is later
  logic                 rden_inc;
  logic                 rden_dec;
  logic                 skew_err;

  always_ff @(posedge clkdiv) begin
    if (rec_i && (rec_grp_i == '0)) begin
      ref_dly <= rec_dly_i;
    end
  end

  always_ff @(posedge clkdiv) begin
    if (rstdiv) begin
      rden_mux   <= '0;
      rden_inc   <= 1'b0;
      rden_dec   <= 1'b0;
      skew_err   <= 1'b0;
      rden_sel_o <= '0;
    end else begin
      if (rec_i) begin
        if (rec_grp_i == '0) begin
          // group 0 always records first, so this opens a new run
          rden_mux <= '0;
          rden_inc <= 1'b0;
          rden_dec <= 1'b0;
        end else if (rec_dly_i != ref_dly) begin
          // only one cycle of spread is handled so any difference counts as one cycle
          rden_mux[rec_grp_i] <= 1'b1;
          if (ref_dly > rec_dly_i) begin
            rden_inc <= 1'b1;
          end else begin
            rden_dec <= 1'b1;
          end
        end
      end
      if (done_i) begin
        // groups spread to both sides of group 0 cannot be compensated
        skew_err <= rden_inc & rden_dec;
        // when group 0 is the late one every group except the early ones
        // takes the extra cycle
        rden_sel_o <= rden_inc ? ~rden_mux : rden_mux;
      end else begin
        // a new start drops done and with it the skew error of the last run
        skew_err <= 1'b0;
      end
    end
  end

  assign calib_err_o = search_err_i | skew_err;

endmodule

// File: source/ddr_rden_cal_top.sv
`timescale 1ns/1ps

module ddr_rden_cal_top
  import rden_cal_pkg::*;
#(
  parameter int DQS_WIDTH = 4
) (
  input  logic                        clkdiv,
  input  logic                        rstdiv,
  input  logic                        calib_start_i,
  input  logic                        ctrl_rden_i,
  input  rdd_sample_t [DQS_WIDTH-1:0] rdd_i,
  output logic                        probe_rden_o,
  output logic                        calib_done_o,
  output logic                        calib_err_o,
  output rden_dly_t   [DQS_WIDTH-1:0] rden_dly_o,
  output logic        [DQS_WIDTH-1:0] rden_sel_o,
  output logic        [DQS_WIDTH-1:0] read_valid_o
);

  localparam int GRP_W = grp_w(DQS_WIDTH);

  logic [DQS_WIDTH-1:0] match_aligned;
  logic [DQS_WIDTH-1:0] match_stgd;
  logic                 probe_valid;
  rden_dly_t            probe_dly;
  logic                 rec;
  logic [GRP_W-1:0]     rec_grp;
  rden_dly_t            rec_dly;
  logic                 search_err;

  // training pattern recognition on the deserialized read data
  rdd_pattern_decode #(
    .DQS_WIDTH (DQS_WIDTH)
  ) u_rdd_pattern_decode (
    .clkdiv          (clkdiv),
    .rdd_i           (rdd_i),
    .match_aligned_o (match_aligned),
    .match_stgd_o    (match_stgd)
  );

  // per-group search for the probe delay that lines up with the pattern
  rden_search_exec #(
    .DQS_WIDTH (DQS_WIDTH)
  ) u_rden_search_exec (
    .clkdiv          (clkdiv),
    .rstdiv          (rstdiv),
    .calib_start_i   (calib_start_i),
    .match_aligned_i (match_aligned),
    .match_stgd_i    (match_stgd),
    .probe_valid_i   (probe_valid),
    .probe_rden_o    (probe_rden_o),
    .probe_dly_o     (probe_dly),
    .grp_dly_o       (rden_dly_o),
    .rec_o           (rec),
    .rec_grp_o       (rec_grp),
    .rec_dly_o       (rec_dly),
    .search_err_o    (search_err),
    .done_o          (calib_done_o)
  );

  // skew select against group 0 and the merged calibration error
  rden_skew_result #(
    .DQS_WIDTH (DQS_WIDTH)
  ) u_rden_skew_result (
    .clkdiv       (clkdiv),
    .rstdiv       (rstdiv),
    .rec_i        (rec),
    .rec_grp_i    (rec_grp),
    .rec_dly_i    (rec_dly),
    .done_i       (calib_done_o),
    .search_err_i (search_err),
    .rden_sel_o   (rden_sel_o),
    .calib_err_o  (calib_err_o)
  );

  // the probe pulse comes back as the valid that qualifies the pattern flags
  rden_delay_line #(
    .NUM_LANES (1)
  ) u_probe_dly (
    .clkdiv (clkdiv),
    .rstdiv (rstdiv),
    .rden_i (probe_rden_o),
    .dly_i  (probe_dly),
    .rden_o (probe_valid)
  );

  // normal reads, one lane per group with that group's calibrated delay
  rden_delay_line #(
    .NUM_LANES (DQS_WIDTH)
  ) u_read_dly (
    .clkdiv (clkdiv),
    .rstdiv (rstdiv),
    .rden_i ({DQS_WIDTH{ctrl_rden_i}}),
    .dly_i  (rden_dly_o),
    .rden_o (read_valid_o)
  );

endmodule

// File: verification/tb_ddr_rden_cal_tasks.svh
`ifndef TB_DDR_RDEN_CAL_TASKS_SVH
`define TB_DDR_RDEN_CAL_TASKS_SVH

// compares one observed value with the value the test expects
task automatic check_value(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
  checks++;
  assert (act === exp) else begin
    $display("error: %s %s expected %0d actual %0d", test, what, exp, act);
    errors++;
  end
endtask

// the new responder setup is written on the rising edge so the responder
// never sees half of it
task automatic load_responder(input int l [DQS_WIDTH], input bit stgd, input bit quiet);
  @(posedge clkdiv);
  lat       = l;
  stgd_fmt  = stgd;
  silent    = quiet;
  probe_cyc = -1000;
endtask

// gives a fresh rising edge on start and waits for done or a search error
task automatic run_calibration(input string test, output bit done_seen, output bit err_seen);
  int waited;
  done_seen = 1'b0;
  err_seen  = 1'b0;
  waited    = 0;
  @(negedge clkdiv);
  calib_start_i = 1'b0;
  @(negedge clkdiv);
  calib_start_i = 1'b1;
  // the old done level drops one edge after start is seen
  repeat (2) @(negedge clkdiv);
  while (!done_seen && !err_seen && (waited < CALIB_LIMIT)) begin
    @(negedge clkdiv);
    waited++;
    done_seen = calib_done_o;
    err_seen  = calib_err_o && !calib_done_o;
  end
  checks++;
  assert (done_seen || err_seen) else begin
    $display("%s: calibration neither finished nor failed within %0d cycles",
             test, CALIB_LIMIT);
    errors++;
  end
  // skew select and skew error follow done by one cycle
  @(negedge clkdiv);
endtask

// every reported delay must equal the latency the responder used
task automatic check_delays(input string test);
  for (int g = 0; g < DQS_WIDTH; g++) begin
    check_value(test, $sformatf("rden_dly_o[%0d]", g), lat[g], rden_dly_o[g]);
  end
endtask

task automatic check_reset_state();
  check_value("reset", "probe_rden_o", 0, probe_rden_o);
  check_value("reset", "calib_done_o", 0, calib_done_o);
  check_value("reset", "calib_err_o", 0, calib_err_o);
  check_value("reset", "read_valid_o", 0, read_valid_o);
endtask

task automatic calibrate_aligned_equal();
  int l [DQS_WIDTH];
  int base;
  bit done_seen;
  bit err_seen;
  base = 3 + int'($urandom % 18);
  foreach (l[g]) begin
    l[g] = base;
  end
  load_responder(l, 1'b0, 1'b0);
  run_calibration("aligned_equal", done_seen, err_seen);
  check_value("aligned_equal", "calib_done_o", 1, done_seen);
  check_delays("aligned_equal");
  check_value("aligned_equal", "rden_sel_o", 0, rden_sel_o);
  check_value("aligned_equal", "calib_err_o", 0, calib_err_o);
endtask

// one read enable pulse must bring each group's valid back exactly once
task automatic replay_normal_reads();
  int c0;
  logic exp_bit;
  @(negedge clkdiv);
  ctrl_rden_i = 1'b1;
  c0 = cyc;
  @(negedge clkdiv);
  ctrl_rden_i = 1'b0;
  repeat (2 ** `RDEN_DLY_W) begin
    for (int g = 0; g < DQS_WIDTH; g++) begin
      exp_bit = (cyc == c0 + lat[g] + 1);
      check_value("normal_reads",
                  $sformatf("read_valid_o[%0d] at offset %0d", g, cyc - c0),
                  exp_bit, read_valid_o[g]);
    end
    @(negedge clkdiv);
  end
endtask

task automatic calibrate_staggered_later();
  int l [DQS_WIDTH];
  int base;
  logic [DQS_WIDTH-1:0] later;
  bit done_seen;
  bit err_seen;
  base  = 3 + int'($urandom % 18);
  // some of groups 1 and up arrive one cycle after group 0
  later = DQS_WIDTH'((1 + int'($urandom % ((2 ** (DQS_WIDTH - 1)) - 1))) << 1);
  foreach (l[g]) begin
    l[g] = base + later[g];
  end
  load_responder(l, 1'b1, 1'b0);
  run_calibration("staggered_later", done_seen, err_seen);
  check_value("staggered_later", "calib_done_o", 1, done_seen);
  check_delays("staggered_later");
  check_value("staggered_later", "rden_sel_o", later, rden_sel_o);
  check_value("staggered_later", "calib_err_o", 0, calib_err_o);
endtask

task automatic calibrate_aligned_earlier();
  int l [DQS_WIDTH];
  int base;
  logic [DQS_WIDTH-1:0] early;
  logic [DQS_WIDTH-1:0] exp_sel;
  bit done_seen;
  bit err_seen;
  base  = 4 + int'($urandom % 17);
  early = DQS_WIDTH'((1 + int'($urandom % ((2 ** (DQS_WIDTH - 1)) - 1))) << 1);
  foreach (l[g]) begin
    l[g] = base - early[g];
  end
  // group 0 is late here, so everyone except the early groups takes the extra cycle
  exp_sel = ~early;
  load_responder(l, 1'b0, 1'b0);
  run_calibration("aligned_earlier", done_seen, err_seen);
  check_value("aligned_earlier", "calib_done_o", 1, done_seen);
  check_delays("aligned_earlier");
  check_value("aligned_earlier", "rden_sel_o", exp_sel, rden_sel_o);
  check_value("aligned_earlier", "calib_err_o", 0, calib_err_o);
endtask

task automatic recover_from_silence();
  int l [DQS_WIDTH];
  int base;
  bit done_seen;
  bit err_seen;
  base = 3 + int'($urandom % 18);
  foreach (l[g]) begin
    l[g] = base;
  end
  load_responder(l, 1'b0, 1'b1);
  run_calibration("silent", done_seen, err_seen);
  check_value("silent", "calib_err_o", 1, err_seen);
  check_value("silent", "calib_done_o", 0, calib_done_o);
  repeat (8) @(negedge clkdiv);
  check_value("silent", "calib_done_o later", 0, calib_done_o);
  check_value("silent", "calib_err_o later", 1, calib_err_o);
  // a normal responder and a new start must clear the error
  load_responder(l, 1'b0, 1'b0);
  run_calibration("silent_restart", done_seen, err_seen);
  check_value("silent_restart", "calib_done_o", 1, done_seen);
  check_delays("silent_restart");
  check_value("silent_restart", "calib_err_o", 0, calib_err_o);
endtask

task automatic detect_two_sided_spread();
  int l [DQS_WIDTH];
  int base;
  bit done_seen;
  bit err_seen;
  base = 4 + int'($urandom % 17);
  foreach (l[g]) begin
    l[g] = base;
  end
  // group 1 is early and group 2 is late against group 0
  l[1] = base - 1;
  l[2] = base + 1;
  load_responder(l, 1'b1, 1'b0);
  run_calibration("spread_both_ways", done_seen, err_seen);
  check_value("spread_both_ways", "calib_done_o", 1, done_seen);
  check_delays("spread_both_ways");
  check_value("spread_both_ways", "calib_err_o", 1, calib_err_o);
endtask

`endif

// File: verification/tb_ddr_rden_cal.sv
`timescale 1ns/1ps

`include "rden_cal_defines.svh"

module tb_ddr_rden_cal
  import rden_cal_pkg::*;
();

  localparam int DQS_WIDTH = 4;
  localparam int CLK_HALF  = 4;
  localparam logic [31:0] SEED = 32'h5335110c;

  // DQ bit 0 of the training burst, beat 0 on the left
  // beat 7 is never checked by the DUT and is driven as a one
  localparam logic [7:0] TRAIN_BIT0 = 8'b1001_0101;

  // one search attempt is the pipe clear wait, the probe and the round trip,
  // which stays under 80 cycles for every delay the search can try
  localparam int MAX_ATTEMPTS   = `RDEN_DLY_MAX - `RDEN_BASE_DELAY + 1;
  localparam int ATTEMPT_CYCLES = 80;
  localparam int CALIB_LIMIT    = DQS_WIDTH * MAX_ATTEMPTS * ATTEMPT_CYCLES;
  // six calibrations are run in total, plus slack for the normal read test
  localparam int NUM_CALIBS     = 6;
  localparam int CYCLE_LIMIT    = NUM_CALIBS * CALIB_LIMIT + 2400;

  logic                        clkdiv;
  logic                        rstdiv;
  logic                        calib_start_i;
  logic                        ctrl_rden_i;
  rdd_sample_t [DQS_WIDTH-1:0] rdd_i;
  logic                        probe_rden_o;
  logic                        calib_done_o;
  logic                        calib_err_o;
  rden_dly_t   [DQS_WIDTH-1:0] rden_dly_o;
  logic        [DQS_WIDTH-1:0] rden_sel_o;
  logic        [DQS_WIDTH-1:0] read_valid_o;

  // clock cycle number, it only changes on the rising edge
  int cyc = 0;
  int errors = 0;
  int checks = 0;

  // responder setup, burst latency per group and the burst format
  int lat [DQS_WIDTH];
  bit stgd_fmt = 1'b0;
  bit silent = 1'b0;
  int probe_cyc = -1000;

  ddr_rden_cal_top #(
    .DQS_WIDTH (DQS_WIDTH)
  ) u_ddr_rden_cal_top (
    .clkdiv        (clkdiv),
    .rstdiv        (rstdiv),
    .calib_start_i (calib_start_i),
    .ctrl_rden_i   (ctrl_rden_i),
    .rdd_i         (rdd_i),
    .probe_rden_o  (probe_rden_o),
    .calib_done_o  (calib_done_o),
    .calib_err_o   (calib_err_o),
    .rden_dly_o    (rden_dly_o),
    .rden_sel_o    (rden_sel_o),
    .read_valid_o  (read_valid_o)
  );

  initial begin
    clkdiv = 1'b0;
    forever #CLK_HALF clkdiv = ~clkdiv;
  end

  always @(posedge clkdiv) begin
    cyc <= cyc + 1;
  end

  // one beat of the burst as {DQ bit 1, DQ bit 0}, bit 1 is the complement
  function automatic logic [1:0] beat(input int k);
    logic b0;
    b0 = TRAIN_BIT0[7-k];
    return {~b0, b0};
  endfunction

  // word idx of a burst as the deserializer delivers it
  function automatic rdd_sample_t burst_word(input bit stgd, input int idx);
    rdd_sample_t w;
    w = '0;
    if (!stgd) begin
      // aligned, two full words of four beats each
      if (idx < 2) begin
        w.rise_q2 = beat(4 * idx);
        w.fall_q2 = beat(4 * idx + 1);
        w.rise_q1 = beat(4 * idx + 2);
        w.fall_q1 = beat(4 * idx + 3);
      end
    end else begin
      // staggered, the burst starts in the q1 half and ends in the q2 half
      case (idx)
        0: begin
          w.rise_q1 = beat(0);
          w.fall_q1 = beat(1);
        end
        1: begin
          w.rise_q2 = beat(2);
          w.fall_q2 = beat(3);
          w.rise_q1 = beat(4);
          w.fall_q1 = beat(5);
        end
        2: begin
          w.rise_q2 = beat(6);
          w.fall_q2 = beat(7);
        end
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  // memory model, each group answers a probe with its first word at
  // probe cycle plus that group's latency and drives zero otherwise
  always @(negedge clkdiv) begin
    int offs;
    if (probe_rden_o) begin
      probe_cyc = cyc;
    end
    for (int g = 0; g < DQS_WIDTH; g++) begin
      offs = cyc - probe_cyc - lat[g];
      if (!silent && (offs >= 0) && (offs <= 2)) begin
        rdd_i[g] = burst_word(stgd_fmt, offs);
      end else begin
        rdd_i[g] = '0;
      end
    end
  end

  `include "tb_ddr_rden_cal_tasks.svh"

  // hard stop in case the DUT never answers
  initial begin
    wait (cyc >= CYCLE_LIMIT);
    $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    foreach (lat[g]) begin
      lat[g] = 0;
    end
    rstdiv        = 1'b1;
    calib_start_i = 1'b0;
    ctrl_rden_i   = 1'b0;
    rdd_i         = '0;
    repeat (2) @(negedge clkdiv);
    rstdiv = 1'b0;

    check_reset_state();
    calibrate_aligned_equal();
    // normal reads reuse the delays of the equal latency run
    replay_normal_reads();
    calibrate_staggered_later();
    calibrate_aligned_earlier();
    // silence runs before the spread test, which leaves the skew error set
    recover_from_silence();
    detect_two_sided_spread();

    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+source
+incdir+verification
source/rden_cal_pkg.sv
source/rdd_pattern_decode.sv
source/rden_delay_line.sv
source/rden_search_exec.sv
source/rden_skew_result.sv
source/ddr_rden_cal_top.sv
verification/tb_ddr_rden_cal.sv
